// File: avl_subsys.f
+incdir+include
design/avl_pkg.sv
design/avl_hold_reg.sv
design/avl_port_arbiter.sv
design/avl_master_ctrl.sv
design/avl_onchip_ram.sv
design/avl_subsys_top.sv
sim/avl_clk_gen.sv
sim/avl_subsys_tb.sv

// File: design/avl_hold_reg.sv
`timescale 1ns/1ps

module avl_hold_reg #(
  parameter type payload_t = logic
) (
  input  logic     m_avl_hclk,
  input  logic     m_avl_hresetn,
  input  logic     load,
  input  payload_t d,
  output payload_t q
);

  // capture on load, otherwise keep
  always_ff @(posedge m_avl_hclk) begin
    if (!m_avl_hresetn) begin
      q <= '0;
    end else if (load) begin
      q <= d;
    end
  end

endmodule

// File: design/avl_master_ctrl.sv
`timescale 1ns/1ps
`include "avl_subsys_defines.svh"

module avl_master_ctrl (
  input  logic                  m_avl_hclk,
  input  logic                  m_avl_hresetn,
  input  logic                  req_valid,
  input  avl_pkg::avl_req_t     req_q,
  output logic                  req_load,
  output logic                  rsp_ready,
  output avl_pkg::avl_rsp_t     rsp_d,
  output logic                  rsp_load,
  output avl_pkg::avl_cmd_t     cmd,
  input  logic                  waitrequest,
  input  avl_pkg::avl_slv_rsp_t slv_rsp
);
  import avl_pkg::*;

  avl_ctrl_state_t state;
  avl_ctrl_state_t state_nxt;
  logic            is_write;
  logic            accept;
  logic            rsp_hit;

  // direction from the held strobes
  assign is_write = |req_q.wstrb;

  // request capture on the IDLE to CMD edge
  assign req_load = (state == CTRL_IDLE) && req_valid;

  // ########################################
  // command toward the slave
  // ########################################

  // fields come from req_q, so they stay put through waitrequest
  always_comb begin
    cmd.address    = req_q.addr;
    cmd.byteenable = req_q.wstrb;
    cmd.writedata  = req_q.wdata;
    cmd.read       = (state == CTRL_CMD) && !is_write;
    cmd.write      = (state == CTRL_CMD) && is_write;
  end

  assign accept = (state == CTRL_CMD) && !waitrequest;

  // ########################################
  // response collection
  // ########################################

  // only the strobe matching the issued direction counts
  assign rsp_hit = (state == CTRL_RESP) &&
                   (is_write ? slv_rsp.writeresponsevalid : slv_rsp.readdatavalid);

  assign rsp_load = rsp_hit;

  always_comb begin
    rsp_d.rdata = is_write ? 32'h0 : slv_rsp.readdata;
    // any code but OKAY is an error, no retry
    rsp_d.err   = (slv_rsp.response != `AVL_RSP_OKAY);
  end

  always_comb begin
    state_nxt = state;
    case (state)
      CTRL_IDLE: begin
        if (req_valid) begin
          state_nxt = CTRL_CMD;
        end
      end
      CTRL_CMD: begin
        if (accept) begin
          state_nxt = CTRL_RESP;
        end
      end
      CTRL_RESP: begin
        if (rsp_hit) begin
          state_nxt = CTRL_IDLE;
        end
      end
      default: state_nxt = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge m_avl_hclk) begin
    if (!m_avl_hresetn) begin
      state     <= CTRL_IDLE;
      rsp_ready <= 1'b0;
    end else begin
      state     <= state_nxt;
      // ready lines up with the freshly loaded rsp_q
      rsp_ready <= rsp_hit;
    end
  end

endmodule

// File: design/avl_onchip_ram.sv
`timescale 1ns/1ps
`include "avl_subsys_defines.svh"

module avl_onchip_ram (
  input  logic                  m_avl_hclk,
  input  logic                  m_avl_hresetn,
  input  avl_pkg::avl_cmd_t     cmd,
  output logic                  waitrequest,
  output avl_pkg::avl_slv_rsp_t slv_rsp
);
  import avl_pkg::*;

  localparam int unsigned RAM_WORDS = 1 << `AVL_RAM_ADDR_BITS;
  localparam int unsigned LAT = `AVL_RAM_READ_LATENCY;

  logic [31:0]                   mem [RAM_WORDS];
  logic [3:0]                    stall_cnt;
  logic                          cmd_active;
  logic                          accept;
  logic                          in_range;
  logic [`AVL_RAM_ADDR_BITS-1:0] word_idx;
  avl_slv_rsp_t                  slot_d;
  avl_slv_rsp_t                  slot [LAT+1];

  // ########################################
  // decode and stall
  // ########################################

  assign cmd_active = cmd.read | cmd.write;
  assign in_range   = (cmd.address[31:`AVL_RAM_ADDR_BITS+2] == '0);
  assign word_idx   = cmd.address[`AVL_RAM_ADDR_BITS+1:2];

  // high from the first cycle a command is seen
  assign waitrequest = cmd_active && (stall_cnt < `AVL_RAM_WAIT_CYCLES);
  assign accept      = cmd_active && !waitrequest;

  always_ff @(posedge m_avl_hclk) begin
    if (!m_avl_hresetn) begin
      stall_cnt <= '0;
    end else if (accept) begin
      stall_cnt <= '0;
    end else if (waitrequest) begin
      stall_cnt <= stall_cnt + 4'd1;
    end
  end

  // ########################################
  // memory array
  // ########################################

  // out-of-range writes are dropped
  always_ff @(posedge m_avl_hclk) begin
    if (accept && cmd.write && in_range) begin
      for (int b = 0; b < 4; b++) begin
        if (cmd.byteenable[b]) begin
          mem[word_idx][8*b +: 8] <= cmd.writedata[8*b +: 8];
        end
      end
    end
  end

  // ########################################
  // response slots
  // ########################################

  always_comb begin
    slot_d = '0;
    if (accept) begin
      slot_d.readdatavalid      = cmd.read;
      slot_d.writeresponsevalid = cmd.write;
      slot_d.response           = in_range ? `AVL_RSP_OKAY : `AVL_RSP_DECODEERROR;
      if (cmd.read && in_range) begin
        slot_d.readdata = mem[word_idx];
      end
    end
  end

  // slot 0 loads on acceptance, slot LAT is what the master sees
  always_ff @(posedge m_avl_hclk) begin
    if (!m_avl_hresetn) begin
      for (int i = 0; i <= LAT; i++) begin
        slot[i] <= '0;
      end
    end else begin
      slot[0] <= slot_d;
      for (int i = 1; i <= LAT; i++) begin
        slot[i] <= slot[i-1];
      end
    end
  end

  assign slv_rsp = slot[LAT];

endmodule

// File: design/avl_pkg.sv
package avl_pkg;

  // ########################################
  // core side
  // ########################################

  // zero wstrb means read
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        instr;
  } avl_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } avl_rsp_t;

  // ########################################
  // Avalon-MM side
  // ########################################

  typedef struct packed {
    logic [31:0] address;
    logic [3:0]  byteenable;
    logic        read;
    logic        write;
    logic [31:0] writedata;
  } avl_cmd_t;

  typedef struct packed {
    logic [31:0] readdata;
    logic [1:0]  response;
    logic        readdatavalid;
    logic        writeresponsevalid;
  } avl_slv_rsp_t;

  // bridge controller states
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_CMD,
    CTRL_RESP
  } avl_ctrl_state_t;

endpackage

// File: design/avl_port_arbiter.sv
`timescale 1ns/1ps

module avl_port_arbiter (
  input  logic              m_avl_hclk,
  input  logic              m_avl_hresetn,
  input  logic              instr_valid,
  input  logic [31:0]       instr_addr,
  input  logic              data_valid,
  input  logic [31:0]       data_addr,
  input  logic [31:0]       data_wdata,
  input  logic [3:0]        data_wstrb,
  output logic              req_valid,
  output avl_pkg::avl_req_t req,
  input  logic              rsp_ready,
  input  avl_pkg::avl_rsp_t rsp,
  output logic [31:0]       instr_rdata,
  output logic              instr_ready,
  output logic              instr_err,
  output logic [31:0]       data_rdata,
  output logic              data_ready,
  output logic              data_err
);

  logic grant_active;
  logic grant_data;
  logic sel_data;

  // ########################################
  // request side
  // ########################################

  // data port wins when nothing is granted
  assign sel_data = grant_active ? grant_data : data_valid;

  // masked during ready so the same request is not issued twice
  assign req_valid = (sel_data ? data_valid : instr_valid) & ~rsp_ready;

  always_comb begin
    req.addr  = sel_data ? data_addr : instr_addr;
    req.wdata = sel_data ? data_wdata : 32'h0;
    // fetches are always reads
    req.wstrb = sel_data ? data_wstrb : 4'h0;
    req.instr = ~sel_data;
  end

  always_ff @(posedge m_avl_hclk) begin
    if (!m_avl_hresetn) begin
      grant_active <= 1'b0;
      grant_data   <= 1'b0;
    end else if (!grant_active && req_valid) begin
      grant_active <= 1'b1;
      grant_data   <= data_valid;
    end else if (rsp_ready) begin
      grant_active <= 1'b0;
    end
  end

  // ########################################
  // response side
  // ########################################

  assign data_ready  = rsp_ready & grant_active & grant_data;
  assign instr_ready = rsp_ready & grant_active & ~grant_data;

  // the port without the grant sees zeros
  assign data_rdata  = data_ready ? rsp.rdata : 32'h0;
  assign data_err    = data_ready & rsp.err;
  assign instr_rdata = instr_ready ? rsp.rdata : 32'h0;
  assign instr_err   = instr_ready & rsp.err;

endmodule

// File: design/avl_subsys_top.sv
`timescale 1ns/1ps

module avl_subsys_top (
  input  logic        m_avl_hclk,
  input  logic        m_avl_hresetn,
  // instruction port
  input  logic        instr_valid,
  input  logic [31:0] instr_addr,
  output logic [31:0] instr_rdata,
  output logic        instr_ready,
  output logic        instr_err,
  // data port
  input  logic        data_valid,
  input  logic [31:0] data_addr,
  input  logic [31:0] data_wdata,
  input  logic [3:0]  data_wstrb,
  output logic [31:0] data_rdata,
  output logic        data_ready,
  output logic        data_err
);
  import avl_pkg::*;

  logic         req_valid;
  avl_req_t     req;
  avl_req_t     req_q;
  logic         req_load;
  logic         rsp_ready;
  logic         rsp_load;
  avl_rsp_t     rsp_d;
  avl_rsp_t     rsp_q;
  avl_cmd_t     cmd;
  logic         waitrequest;
  avl_slv_rsp_t slv_rsp;

  avl_port_arbiter arb0 (
    .m_avl_hclk    (m_avl_hclk),
    .m_avl_hresetn (m_avl_hresetn),
    .instr_valid   (instr_valid),
    .instr_addr    (instr_addr),
    .data_valid    (data_valid),
    .data_addr     (data_addr),
    .data_wdata    (data_wdata),
    .data_wstrb    (data_wstrb),
    .req_valid     (req_valid),
    .req           (req),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp_q),
    .instr_rdata   (instr_rdata),
    .instr_ready   (instr_ready),
    .instr_err     (instr_err),
    .data_rdata    (data_rdata),
    .data_ready    (data_ready),
    .data_err      (data_err)
  );

  avl_master_ctrl ctrl0 (
    .m_avl_hclk    (m_avl_hclk),
    .m_avl_hresetn (m_avl_hresetn),
    .req_valid     (req_valid),
    .req_q         (req_q),
    .req_load      (req_load),
    .rsp_ready     (rsp_ready),
    .rsp_d         (rsp_d),
    .rsp_load      (rsp_load),
    .cmd           (cmd),
    .waitrequest   (waitrequest),
    .slv_rsp       (slv_rsp)
  );

  // request capture, frozen for the whole transfer
  avl_hold_reg #(.payload_t(avl_req_t)) req_reg0 (
    .m_avl_hclk    (m_avl_hclk),
    .m_avl_hresetn (m_avl_hresetn),
    .load          (req_load),
    .d             (req),
    .q             (req_q)
  );

  avl_hold_reg #(.payload_t(avl_rsp_t)) rsp_reg0 (
    .m_avl_hclk    (m_avl_hclk),
    .m_avl_hresetn (m_avl_hresetn),
    .load          (rsp_load),
    .d             (rsp_d),
    .q             (rsp_q)
  );

  avl_onchip_ram ram0 (
    .m_avl_hclk    (m_avl_hclk),
    .m_avl_hresetn (m_avl_hresetn),
    .cmd           (cmd),
    .waitrequest   (waitrequest),
    .slv_rsp       (slv_rsp)
  );

endmodule

// File: include/avl_subsys_defines.svh
`ifndef AVL_SUBSYS_DEFINES_SVH
`define AVL_SUBSYS_DEFINES_SVH

// ########################################
// on-chip RAM geometry and timing
// ########################################

// word address bits, 1024 words
`define AVL_RAM_ADDR_BITS 10
// waitrequest cycles once a command shows up
`define AVL_RAM_WAIT_CYCLES 1
// acceptance to readdatavalid / writeresponsevalid
`define AVL_RAM_READ_LATENCY 2

// ########################################
// Avalon response codes
// ########################################

`define AVL_RSP_OKAY 2'b00
`define AVL_RSP_DECODEERROR 2'b11

`endif

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module avl_subsys_tb -f avl_subsys.f -o avl_subsys_sim \
  && out="$(./obj_dir/avl_subsys_sim)" \
  && echo "$out" \
  && echo "$out" | grep -qx "STATUS: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim/avl_clk_gen.sv
`timescale 1ns/1ps

module avl_clk_gen (
  output logic m_avl_hclk,
  output logic m_avl_hresetn
);

  // 8 ns period
  initial begin
    m_avl_hclk = 1'b0;
    forever #4 m_avl_hclk = ~m_avl_hclk;
  end

  // released after 16 rising edges
  initial begin
    m_avl_hresetn = 1'b0;
    repeat (16) @(posedge m_avl_hclk);
    m_avl_hresetn <= 1'b1;
  end

endmodule

// File: sim/avl_subsys_tb.sv
`timescale 1ns/1ps
`include "avl_subsys_defines.svh"

module avl_subsys_tb;
  import avl_pkg::*;

  localparam int unsigned RAM_WORDS = 1 << `AVL_RAM_ADDR_BITS;
  localparam int unsigned RAM_BYTES = 4 << `AVL_RAM_ADDR_BITS;
  // tests 2 to 6 in transfers
  localparam int NUM_TXN = 128 + 64 + 32 + 16 + 24;
  localparam int TIMEOUT_CYCLES = NUM_TXN * 16 + 100;

  logic        m_avl_hclk;
  logic        m_avl_hresetn;
  logic        instr_valid;
  logic [31:0] instr_addr;
  logic [31:0] instr_rdata;
  logic        instr_ready;
  logic        instr_err;
  logic        data_valid;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [3:0]  data_wstrb;
  logic [31:0] data_rdata;
  logic        data_ready;
  logic        data_err;

  logic [31:0]                   shadow [RAM_WORDS];
  bit                            known [RAM_WORDS];
  logic [`AVL_RAM_ADDR_BITS-1:0] written [$];
  avl_rsp_t                      exp_data_q [$];
  avl_rsp_t                      exp_instr_q [$];
  int                            pass_cnt;
  int                            err_cnt;
  int                            pass_base;
  int                            err_base;
  int                            cycle_cnt;
  time                           data_ready_t;
  time                           instr_ready_t;

  avl_clk_gen clk0 (
    .m_avl_hclk    (m_avl_hclk),
    .m_avl_hresetn (m_avl_hresetn)
  );

  avl_subsys_top dut0 (.*);

  // ########################################
  // reference model
  // ########################################

  function automatic logic in_ram(input logic [31:0] addr);
    return addr < RAM_BYTES;
  endfunction

  // zero outside the RAM
  function automatic logic [31:0] exp_read(input logic [31:0] addr);
    if (!in_ram(addr)) begin
      return 32'h0;
    end
    return shadow[addr[`AVL_RAM_ADDR_BITS+1:2]];
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] wstrb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] word_addr(input logic [`AVL_RAM_ADDR_BITS-1:0] idx);
    return 32'(idx) << 2;
  endfunction

  function automatic logic [`AVL_RAM_ADDR_BITS-1:0] pick_written();
    return written[$urandom_range(0, written.size() - 1)];
  endfunction

  // ########################################
  // drivers
  // ########################################

  task automatic report_error(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d checks passed, %0d errors", num, name,
             pass_cnt - pass_base, err_cnt - err_base);
    pass_base = pass_cnt;
    err_base  = err_cnt;
  endtask

  task automatic data_req(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb);
    avl_rsp_t                      e;
    logic [`AVL_RAM_ADDR_BITS-1:0] idx;
    idx     = addr[`AVL_RAM_ADDR_BITS+1:2];
    e.err   = !in_ram(addr);
    e.rdata = (wstrb == 4'h0) ? exp_read(addr) : 32'h0;
    if ((wstrb != 4'h0) && in_ram(addr)) begin
      shadow[idx] = merge_bytes(shadow[idx], wdata, wstrb);
      if (!known[idx]) begin
        known[idx] = 1'b1;
        written.push_back(idx);
      end
    end
    exp_data_q.push_back(e);
    data_valid <= 1'b1;
    data_addr  <= addr;
    data_wdata <= wdata;
    data_wstrb <= wstrb;
  endtask

  task automatic fetch_req(input logic [31:0] addr);
    avl_rsp_t e;
    e.err   = !in_ram(addr);
    e.rdata = exp_read(addr);
    exp_instr_q.push_back(e);
    instr_valid <= 1'b1;
    instr_addr  <= addr;
  endtask

  // hold each valid until its ready and drop it on the next edge
  task automatic wait_ready(input logic want_data, input logic want_instr);
    logic d_done;
    logic i_done;
    logic d_seen;
    logic i_seen;
    d_done = !want_data;
    i_done = !want_instr;
    while (!(d_done && i_done)) begin
      @(negedge m_avl_hclk);
      d_seen = data_ready;
      i_seen = instr_ready;
      @(posedge m_avl_hclk);
      if (d_seen) begin
        data_valid <= 1'b0;
        d_done = 1'b1;
      end
      if (i_seen) begin
        instr_valid <= 1'b0;
        i_done = 1'b1;
      end
    end
  endtask

  task automatic data_op(input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb);
    @(posedge m_avl_hclk);
    data_req(addr, wdata, wstrb);
    wait_ready(1'b1, 1'b0);
  endtask

  task automatic fetch_op(input logic [31:0] addr);
    @(posedge m_avl_hclk);
    fetch_req(addr);
    wait_ready(1'b0, 1'b1);
  endtask

  // ########################################
  // compare and watchdog
  // ########################################

  initial begin : compare
    avl_rsp_t e;
    forever begin
      @(negedge m_avl_hclk);
      if (data_ready) begin
        data_ready_t = $time;
        if (exp_data_q.size() == 0) begin
          $display("data_ready pulsed at %0t with no data request open", $time);
          err_cnt++;
        end else begin
          e = exp_data_q.pop_front();
          if (data_rdata !== e.rdata) begin
            report_error("data_rdata", data_rdata, e.rdata);
          end else begin
            pass_cnt++;
          end
          if (data_err !== e.err) begin
            report_error("data_err", {31'h0, data_err}, {31'h0, e.err});
          end else begin
            pass_cnt++;
          end
        end
      end
      if (instr_ready) begin
        instr_ready_t = $time;
        if (exp_instr_q.size() == 0) begin
          $display("instr_ready pulsed at %0t with no fetch open", $time);
          err_cnt++;
        end else begin
          e = exp_instr_q.pop_front();
          if (instr_rdata !== e.rdata) begin
            report_error("instr_rdata", instr_rdata, e.rdata);
          end else begin
            pass_cnt++;
          end
          if (instr_err !== e.err) begin
            report_error("instr_err", {31'h0, instr_err}, {31'h0, e.err});
          end else begin
            pass_cnt++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge m_avl_hclk);
      cycle_cnt++;
    end
    $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  // ########################################
  // tests
  // ########################################

  initial begin : main
    logic [31:0]                   a;
    logic [3:0]                    s;
    logic [`AVL_RAM_ADDR_BITS-1:0] idx;
    void'($urandom(32'hb32b25eb));
    instr_valid = 1'b0;
    instr_addr  = 32'h0;
    data_valid  = 1'b0;
    data_addr   = 32'h0;
    data_wdata  = 32'h0;
    data_wstrb  = 4'h0;
    pass_cnt    = 0;
    err_cnt     = 0;
    pass_base   = 0;
    err_base    = 0;
    @(posedge m_avl_hresetn);

    repeat (20) begin
      @(negedge m_avl_hclk);
      if (data_ready !== 1'b0) begin
        report_error("data_ready", {31'h0, data_ready}, 32'h0);
      end else begin
        pass_cnt++;
      end
      if (instr_ready !== 1'b0) begin
        report_error("instr_ready", {31'h0, instr_ready}, 32'h0);
      end else begin
        pass_cnt++;
      end
    end
    end_test(1, "idle after reset");

    repeat (64) begin
      a = $urandom_range(0, RAM_WORDS - 1) * 4;
      data_op(a, $urandom, 4'hf);
      data_op(a, 32'h0, 4'h0);
    end
    end_test(2, "full-word write and read");

    repeat (32) begin
      a = word_addr(pick_written());
      s = 4'($urandom_range(1, 15));
      data_op(a, $urandom, s);
      data_op(a, 32'h0, 4'h0);
    end
    end_test(3, "partial writes");

    repeat (32) begin
      fetch_op(word_addr(pick_written()));
    end
    end_test(4, "instruction fetch");

    // data must win when both ports rise on one edge
    repeat (8) begin
      @(posedge m_avl_hclk);
      data_req(word_addr(pick_written()), 32'h0, 4'h0);
      fetch_req(word_addr(pick_written()));
      wait_ready(1'b1, 1'b1);
      if (data_ready_t >= instr_ready_t) begin
        $display("instr_ready at %0t did not come after data_ready at %0t",
                 instr_ready_t, data_ready_t);
        err_cnt++;
      end else begin
        pass_cnt++;
      end
    end
    end_test(5, "simultaneous requests");

    for (int i = 0; i < 4; i++) begin
      a = (i[0] ? 32'h8000_0000 : RAM_BYTES) + $urandom_range(0, RAM_WORDS - 1) * 4;
      data_op(a, 32'h0, 4'h0);
      idx = pick_written();
      // would alias this live word if the high bits were ignored
      data_op(RAM_BYTES + word_addr(idx), $urandom, 4'hf);
      data_op(word_addr(idx), 32'h0, 4'h0);
    end
    repeat (12) begin
      data_op(word_addr(pick_written()), 32'h0, 4'h0);
    end
    end_test(6, "out-of-range access");

    $display("checks passed %0d, errors %0d", pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
